// ==== logic/cx4_pkg.sv ====
package cx4_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and address map
  ////////////////////////////////////////////////////////////////////////////

  localparam int host_addr_w   = 13;
  localparam int bus_addr_w    = 24;
  localparam int datram_addr_w = 12;

  localparam logic [7:0] mmio_page = 8'hfa; // ADDR[12:5] of 0x1f40..0x1f5f
  localparam logic [4:0] mmio_last = 5'h13; // status from here up

  localparam int wr_settle = 5;             // nWR low cycles before commit

  // status byte layout
  localparam int status_active_bit = 6;
  localparam int status_idle_bit   = 1;

  localparam logic [7:0] r1f50_mask = 8'h77;

  ////////////////////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [23:0] src;   // bus source, bit 15 skipped when mapped
    logic [15:0] len;   // byte count
    logic [23:0] tgt;   // only low 12 bits reach the RAM
  } dma_cfg_t;

  typedef struct packed {
    logic [host_addr_w-1:0] addr;
    logic [7:0]             data;
    logic                   mmio_we;
    logic                   ram_we;
  } host_wr_t;

  typedef struct packed {
    logic [datram_addr_w-1:0] addr;
    logic [7:0]               data;
    logic                     we;
  } ram_wr_t;

endpackage

// ==== logic/cx4_host_port.sv ====
module cx4_host_port
  import cx4_pkg::*;
(
  input  logic                   CLK,
  input  logic                   reset,
  input  logic [7:0]             DI,
  input  logic [host_addr_w-1:0] ADDR,
  input  logic                   CS,
  input  logic                   nWR,
  input  logic [7:0]             mmio_rdata,
  input  logic [7:0]             ram_rdata,
  input  logic                   busy,
  output logic [7:0]             DO,
  output host_wr_t               host_wr
);

  logic [7:0]         di_r;
  logic [wr_settle:0] nwr_sreg;   // msb is the oldest sample
  logic               wr_stb;
  logic               page_hit;
  logic               ram_sel;
  logic               mmio_sel;
  logic               status_sel;
  logic [7:0]         status_byte;

  ////////////////////////////////////////////////////////////////////////////
  // write strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    di_r <= DI;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      nwr_sreg <= '1;  // idle bus, no pending write
    end else begin
      nwr_sreg <= {nwr_sreg[wr_settle-1:0], nWR};
    end
  end

  // one high then wr_settle lows, fires once per write
  assign wr_stb = (nwr_sreg == {1'b1, {wr_settle{1'b0}}});

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  assign page_hit   = (ADDR[12:5] == mmio_page);
  assign ram_sel    = CS & (ADDR[11:0] < 12'hc00);   // 3 KB window
  assign mmio_sel   = CS & page_hit & (ADDR[4:0] < mmio_last);
  assign status_sel = CS & page_hit & (ADDR[4:0] >= mmio_last);

  assign host_wr.addr    = ADDR;
  assign host_wr.data    = di_r;
  assign host_wr.mmio_we = mmio_sel & wr_stb;
  assign host_wr.ram_we  = ram_sel & wr_stb;

  always_comb begin
    status_byte                    = 8'h00;
    status_byte[status_active_bit] = busy;
    status_byte[status_idle_bit]   = ~busy;
  end

  always_comb begin
    if (ram_sel) begin
      DO = ram_rdata;
    end else if (mmio_sel) begin
      DO = mmio_rdata;
    end else if (status_sel) begin
      DO = status_byte;
    end else begin
      DO = 8'h00;
    end
  end

endmodule

// ==== logic/cx4_mmio_regs.sv ====
module cx4_mmio_regs
  import cx4_pkg::*;
(
  input  logic       CLK,
  input  logic       reset,
  input  host_wr_t   host_wr,
  input  logic [4:0] rd_offset,
  output logic [7:0] rdata,
  output dma_cfg_t   dma_cfg,
  output logic       dma_start
);

  logic [7:0] r1f50;
  logic       r1f51;
  logic       r1f52;
  logic [4:0] wr_offset;
  logic [7:0] wr_data;

  assign wr_offset = host_wr.addr[4:0];
  assign wr_data   = host_wr.data;

  ////////////////////////////////////////////////////////////////////////////
  // register writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      dma_cfg   <= '0;
      r1f50     <= 8'h33;
      r1f51     <= 1'b0;
      r1f52     <= 1'b1;
      dma_start <= 1'b0;
    end else begin
      dma_start <= 1'b0;
      if (host_wr.mmio_we) begin
        case (wr_offset)
          5'h00: dma_cfg.src[7:0]   <= wr_data;
          5'h01: dma_cfg.src[15:8]  <= wr_data;
          5'h02: dma_cfg.src[23:16] <= wr_data;
          5'h03: dma_cfg.len[7:0]   <= wr_data;
          5'h04: dma_cfg.len[15:8]  <= wr_data;
          5'h05: dma_cfg.tgt[7:0]   <= wr_data;
          5'h06: dma_cfg.tgt[15:8]  <= wr_data;
          5'h07: begin
            dma_cfg.tgt[23:16] <= wr_data;
            dma_start          <= 1'b1;   // top byte kicks off the copy
          end
          5'h10: r1f50 <= wr_data & r1f50_mask;
          5'h11: r1f51 <= wr_data[0];
          5'h12: r1f52 <= wr_data[0];
          default: ;                      // 0x08..0x0f dropped
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (rd_offset)
      5'h00:   rdata <= dma_cfg.src[7:0];
      5'h01:   rdata <= dma_cfg.src[15:8];
      5'h02:   rdata <= dma_cfg.src[23:16];
      5'h03:   rdata <= dma_cfg.len[7:0];
      5'h04:   rdata <= dma_cfg.len[15:8];
      5'h05:   rdata <= dma_cfg.tgt[7:0];
      5'h06:   rdata <= dma_cfg.tgt[15:8];
      5'h07:   rdata <= dma_cfg.tgt[23:16];
      5'h10:   rdata <= r1f50;
      5'h11:   rdata <= {7'b0, r1f51};
      5'h12:   rdata <= {7'b0, r1f52};
      default: rdata <= 8'hff;
    endcase
  end

endmodule

// ==== logic/cx4_dma_engine.sv ====
module cx4_dma_engine
  import cx4_pkg::*;
#(
  parameter int datram_size = 3072
) (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  dma_start,
  input  dma_cfg_t              dma_cfg,
  input  logic                  BUS_RDY,
  input  logic [7:0]            BUS_DI,
  output logic [bus_addr_w-1:0] BUS_ADDR,
  output logic                  BUS_RRQ,
  output logic                  busy,
  output ram_wr_t               ram_wr
);

  localparam logic [3:0] st_idle  = 4'b0001;
  localparam logic [3:0] st_start = 4'b0010;
  localparam logic [3:0] st_wait  = 4'b0100;
  localparam logic [3:0] st_adv   = 4'b1000;

  logic [3:0]               state;
  logic [23:0]              src_r;
  logic [datram_addr_w-1:0] tgt_r;
  logic [15:0]              count;
  logic [7:0]               data_r;
  logic                     we_r;

  // bit 15 dropped, top bit forced low
  assign BUS_ADDR = {1'b0, src_r[23:16], src_r[14:0]};

  assign ram_wr.addr = tgt_r;
  assign ram_wr.data = data_r;
  assign ram_wr.we   = we_r;

  always_ff @(posedge CLK) begin
    data_r <= (state == st_wait) ? BUS_DI : data_r;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state   <= st_idle;
      BUS_RRQ <= 1'b0;
      busy    <= 1'b0;
      we_r    <= 1'b0;
      src_r   <= '0;
      tgt_r   <= '0;
      count   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (dma_start) begin
            busy  <= 1'b1;
            state <= st_start;
          end
        end
        st_start: begin
          src_r   <= dma_cfg.src;
          tgt_r   <= dma_cfg.tgt[datram_addr_w-1:0];   // RAM is 12 bits deep
          count   <= dma_cfg.len;
          BUS_RRQ <= 1'b1;
          state   <= st_wait;
        end
        st_wait: begin
          BUS_RRQ <= 1'b0;
          if (!BUS_RRQ && BUS_RDY) begin   // rdy ignored in the request cycle
            we_r  <= 1'b1;
            count <= count - 16'd1;
            state <= st_adv;
          end
        end
        st_adv: begin
          we_r  <= 1'b0;
          src_r <= src_r + 24'd1;
          tgt_r <= tgt_r + 1'b1;
          if (count == 16'h0000) begin
            busy  <= 1'b0;
            state <= st_idle;
          end else begin
            BUS_RRQ <= 1'b1;
            state   <= st_wait;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  a_no_rrq_idle: assert property (@(posedge CLK) disable iff (reset)
    (state == st_idle) |-> !BUS_RRQ);

  a_wr_in_ram: assert property (@(posedge CLK) disable iff (reset)
    ram_wr.we |-> (ram_wr.addr < datram_size));

endmodule

// ==== logic/cx4_datram.sv ====
module cx4_datram
  import cx4_pkg::*;
#(
  parameter int datram_size = 3072
) (
  input  logic                     CLK,
  input  host_wr_t                 host_wr,
  input  logic [datram_addr_w-1:0] rd_addr,
  output logic [7:0]               rdata,
  input  ram_wr_t                  dma_wr
);

  logic [7:0] mem [0:datram_size-1];

  always_ff @(posedge CLK) begin
    rdata <= mem[rd_addr];
  end

  always_ff @(posedge CLK) begin
    if (host_wr.ram_we) begin
      mem[host_wr.addr[datram_addr_w-1:0]] <= host_wr.data;
    end
    if (dma_wr.we) begin
      mem[dma_wr.addr] <= dma_wr.data;   // later write, dma wins a collision
    end
  end

  // host window decode must keep writes inside the array
  a_host_in_ram: assert property (@(posedge CLK)
    host_wr.ram_we |-> (host_wr.addr[datram_addr_w-1:0] < datram_size));

endmodule

// ==== logic/cx4_top.sv ====
module cx4_top
  import cx4_pkg::*;
#(
  parameter int datram_size = 3072
) (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic [7:0]             DI,
  output logic [7:0]             DO,
  input  logic [host_addr_w-1:0] ADDR,
  input  logic                   CS,
  input  logic                   nWR,
  output logic [bus_addr_w-1:0]  BUS_ADDR,
  output logic                   BUS_RRQ,
  input  logic                   BUS_RDY,
  input  logic [7:0]             BUS_DI,
  output logic                   cx4_active
);

  host_wr_t   host_wr;
  dma_cfg_t   dma_cfg;
  ram_wr_t    dma_wr;
  logic       dma_start;
  logic       busy;
  logic [7:0] mmio_rdata;
  logic [7:0] ram_rdata;

  assign cx4_active = busy;

  ////////////////////////////////////////////////////////////////////////////
  // host side
  ////////////////////////////////////////////////////////////////////////////

  cx4_host_port u_host_port (
    .CLK        (CLK),
    .reset      (reset),
    .DI         (DI),
    .ADDR       (ADDR),
    .CS         (CS),
    .nWR        (nWR),
    .mmio_rdata (mmio_rdata),
    .ram_rdata  (ram_rdata),
    .busy       (busy),
    .DO         (DO),
    .host_wr    (host_wr)
  );

  cx4_mmio_regs u_mmio_regs (
    .CLK       (CLK),
    .reset     (reset),
    .host_wr   (host_wr),
    .rd_offset (ADDR[4:0]),
    .rdata     (mmio_rdata),
    .dma_cfg   (dma_cfg),
    .dma_start (dma_start)
  );

  ////////////////////////////////////////////////////////////////////////////
  // dma and RAM
  ////////////////////////////////////////////////////////////////////////////

  cx4_dma_engine #(
    .datram_size (datram_size)
  ) u_dma_engine (
    .CLK       (CLK),
    .reset     (reset),
    .dma_start (dma_start),
    .dma_cfg   (dma_cfg),
    .BUS_RDY   (BUS_RDY),
    .BUS_DI    (BUS_DI),
    .BUS_ADDR  (BUS_ADDR),
    .BUS_RRQ   (BUS_RRQ),
    .busy      (busy),
    .ram_wr    (dma_wr)
  );

  cx4_datram #(
    .datram_size (datram_size)
  ) u_datram (
    .CLK     (CLK),
    .host_wr (host_wr),
    .rd_addr (ADDR[datram_addr_w-1:0]),   // port A read follows the host address
    .rdata   (ram_rdata),
    .dma_wr  (dma_wr)
  );

endmodule

// ==== dv/cx4_bus_model.sv ====
module cx4_bus_model
  import cx4_pkg::*;
(
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  slow,
  input  logic [bus_addr_w-1:0] BUS_ADDR,
  input  logic                  BUS_RRQ,
  output logic                  BUS_RDY,
  output logic [7:0]            BUS_DI
);

  timeunit 1ns;
  timeprecision 1ps;

  integer                seed = 32'h69c5b10b;
  logic                  rdy_r = 1'b0;
  logic [7:0]            data_r = 8'h00;
  logic [bus_addr_w-1:0] addr_r;
  logic [5:0]            delay;
  logic                  pending;
  logic [31:0]           rnd;

  assign BUS_RDY = rdy_r;
  assign BUS_DI  = data_r;

  always @(posedge CLK) begin
    if (reset) begin
      rdy_r   <= 1'b0;
      pending <= 1'b0;
      delay   <= 6'd0;
    end else if (BUS_RRQ) begin
      rnd = $random(seed);
      addr_r  <= BUS_ADDR;
      pending <= 1'b1;
      rdy_r   <= 1'b0;
      delay   <= slow ? 6'd10 + 6'(rnd % 31) : 6'd1 + 6'(rnd % 6);  // 10..40 or 1..6
    end else if (pending) begin
      if (delay == 6'd1) begin
        rdy_r   <= 1'b1;
        data_r  <= addr_r[7:0] ^ addr_r[23:16];  // memory content is a function of address
        pending <= 1'b0;
      end else begin
        delay <= delay - 6'd1;
      end
    end else begin
      rdy_r <= 1'b0;   // rdy lasts one cycle
    end
  end

endmodule

// ==== dv/tb_cx4.sv ====
module tb_cx4
  import cx4_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [2:0]  op_wr       = 3'd0;
  localparam logic [2:0]  op_rd       = 3'd1;
  localparam logic [2:0]  op_rd_nocs  = 3'd2;  // read with CS low
  localparam logic [2:0]  op_dma      = 3'd3;  // addr is the target and data[0] picks the slow bus
  localparam logic [2:0]  op_wait     = 3'd4;
  localparam logic [23:0] dma_src     = 24'h5c80f0;  // bit 15 set
  localparam logic [15:0] dma_len     = 16'd20;
  localparam logic [12:0] status_addr = 13'h1f53;
  localparam int          busy_polls  = 40;
  localparam int          idle_polls  = 1000;

  typedef struct packed {
    logic [2:0]  test;
    logic [2:0]  op;
    logic [12:0] addr;
    logic [7:0]  data;
    logic [7:0]  expv;
  } step_t;

  logic                   CLK = 1'b0;
  logic                   reset;
  logic [7:0]             DI;
  logic [7:0]             DO;
  logic [host_addr_w-1:0] ADDR;
  logic                   CS;
  logic                   nWR;
  logic [bus_addr_w-1:0]  BUS_ADDR;
  logic                   BUS_RRQ;
  logic                   BUS_RDY;
  logic [7:0]             BUS_DI;
  logic                   cx4_active;
  logic                   bus_slow;

  step_t steps [$];
  int    checks;
  int    errors;
  int    mark_checks;
  int    mark_errors;
  logic  timed_out;

  always #20 CLK = ~CLK;

  cx4_top dut0 (
    .CLK        (CLK),
    .reset      (reset),
    .DI         (DI),
    .DO         (DO),
    .ADDR       (ADDR),
    .CS         (CS),
    .nWR        (nWR),
    .BUS_ADDR   (BUS_ADDR),
    .BUS_RRQ    (BUS_RRQ),
    .BUS_RDY    (BUS_RDY),
    .BUS_DI     (BUS_DI),
    .cx4_active (cx4_active)
  );

  cx4_bus_model u_bus (
    .CLK      (CLK),
    .reset    (reset),
    .slow     (bus_slow),
    .BUS_ADDR (BUS_ADDR),
    .BUS_RRQ  (BUS_RRQ),
    .BUS_RDY  (BUS_RDY),
    .BUS_DI   (BUS_DI)
  );

  //////////////////////////////////////////////////////////////////////////
  // expected values and checking
  //////////////////////////////////////////////////////////////////////////

  // byte served for a source address with bit 15 skipped by the mapping
  function automatic logic [7:0] exp_byte(input logic [23:0] src);
    logic [23:0] mapped;
    mapped = {1'b0, src[23:16], src[14:0]};
    return mapped[7:0] ^ mapped[23:16];
  endfunction

  function automatic string test_name(input logic [2:0] t);
    case (t)
      3'd1:    return "reset values";
      3'd2:    return "mmio access";
      3'd3:    return "host ram access";
      3'd4:    return "dma transfer";
      3'd5:    return "dma back-pressure";
      default: return "unnamed";
    endcase
  endfunction

  task automatic compare(input logic [7:0] got, input logic [7:0] expv, input string what);
    checks++;
    if (got !== expv) begin
      errors++;
      $display("MISMATCH at %0d ns: %s, got 0x%02h, expected 0x%02h", $time, what, got, expv);
    end
  endtask

  task automatic add_step(input logic [2:0] t, input logic [2:0] o, input logic [12:0] a,
                          input logic [7:0] d, input logic [7:0] e);
    step_t s;
    s.test = t;
    s.op   = o;
    s.addr = a;
    s.data = d;
    s.expv = e;
    steps.push_back(s);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // host bus access
  //////////////////////////////////////////////////////////////////////////

  task automatic host_write(input logic [12:0] a, input logic [7:0] d);
    @(posedge CLK);
    ADDR <= a;
    DI   <= d;
    CS   <= 1'b1;
    nWR  <= 1'b0;
    repeat (wr_settle + 3) @(posedge CLK);  // past the strobe and commit
    nWR <= 1'b1;
    repeat (2) @(posedge CLK);
  endtask

  task automatic host_read(input logic [12:0] a, input logic cs, output logic [7:0] d);
    @(posedge CLK);
    ADDR <= a;
    CS   <= cs;
    nWR  <= 1'b1;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    d = DO;
  endtask

  task automatic program_dma(input logic [11:0] tgt, input logic slow);
    logic [63:0] cfg;
    int          k;
    cfg = {12'h000, tgt, dma_len, dma_src};  // offsets 0x00..0x07 from the lsb up
    @(posedge CLK);
    bus_slow <= slow;
    for (k = 0; k < 8; k++) begin
      host_write(13'h1f40 + 13'(k), cfg[8*k +: 8]);
    end
  endtask

  task automatic wait_dma_done();
    logic [7:0] st;
    int         polls;
    st    = 8'h00;
    polls = 0;
    while (st != 8'h40 && polls < busy_polls) begin
      host_read(status_addr, 1'b1, st);
      polls++;
    end
    if (st != 8'h40) begin
      $display("timeout: status never showed the DMA as busy");
      timed_out = 1'b1;
    end else begin
      polls = 0;
      while (st != 8'h02 && polls < idle_polls) begin
        host_read(status_addr, 1'b1, st);
        polls++;
      end
      if (st != 8'h02) begin
        $display("timeout: DMA transfer never returned to idle");
        timed_out = 1'b1;
      end else begin
        compare({7'b0, cx4_active}, 8'h00, "cx4_active after transfer");
      end
    end
  endtask

  task automatic run_step(input step_t s);
    logic [7:0] got;
    case (s.op)
      op_wr: host_write(s.addr, s.data);
      op_rd: begin
        host_read(s.addr, 1'b1, got);
        compare(got, s.expv, $sformatf("read 0x%04h", s.addr));
      end
      op_rd_nocs: begin
        host_read(s.addr, 1'b0, got);
        compare(got, s.expv, $sformatf("read 0x%04h with CS low", s.addr));
      end
      op_dma:  program_dma(s.addr[11:0], s.data[0]);
      op_wait: wait_dma_done();
      default: ;
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [63:0] regs;
    int          i;
    add_step(3'd1, op_rd, 13'h1f50, 8'h00, 8'h33);
    add_step(3'd1, op_rd, 13'h1f51, 8'h00, 8'h00);
    add_step(3'd1, op_rd, 13'h1f52, 8'h00, 8'h01);
    add_step(3'd1, op_rd, status_addr, 8'h00, 8'h02);
    add_step(3'd1, op_rd, 13'h1f40, 8'h00, 8'h00);
    add_step(3'd1, op_rd, 13'h1f44, 8'h00, 8'h00);
    // 5 byte copy to 0xb00 kicked off by the 0x07 write
    regs = 64'h5e0b_0000_0543_b2a1;
    for (i = 0; i < 8; i++) begin
      add_step(3'd2, op_wr, 13'h1f40 + 13'(i), regs[8*i +: 8], 8'h00);
    end
    add_step(3'd2, op_wait, 13'h0000, 8'h00, 8'h00);
    for (i = 0; i < 8; i++) begin
      add_step(3'd2, op_rd, 13'h1f40 + 13'(i), 8'h00, regs[8*i +: 8]);
    end
    add_step(3'd2, op_wr, 13'h1f50, 8'hff, 8'h00);
    add_step(3'd2, op_rd, 13'h1f50, 8'h00, 8'h77);
    add_step(3'd2, op_wr, 13'h1f4a, 8'h12, 8'h00);
    add_step(3'd2, op_rd, 13'h1f4a, 8'h00, 8'hff);
    add_step(3'd2, op_rd, 13'h1f49, 8'h00, 8'hff);
    add_step(3'd3, op_wr, 13'h0000, 8'h5a, 8'h00);
    add_step(3'd3, op_wr, 13'h03ff, 8'hc3, 8'h00);
    add_step(3'd3, op_wr, 13'h0456, 8'h17, 8'h00);
    add_step(3'd3, op_wr, 13'h0bff, 8'h81, 8'h00);
    add_step(3'd3, op_rd, 13'h0000, 8'h00, 8'h5a);
    add_step(3'd3, op_rd, 13'h03ff, 8'h00, 8'hc3);
    add_step(3'd3, op_rd, 13'h0456, 8'h00, 8'h17);
    add_step(3'd3, op_rd, 13'h0bff, 8'h00, 8'h81);
    add_step(3'd3, op_rd_nocs, 13'h0000, 8'h00, 8'h00);
    add_step(3'd4, op_dma, 13'h0123, 8'h00, 8'h00);
    add_step(3'd4, op_wait, 13'h0000, 8'h00, 8'h00);
    for (i = 0; i < 20; i++) begin
      add_step(3'd4, op_rd, 13'h0123 + 13'(i), 8'h00, exp_byte(dma_src + 24'(i)));
    end
    // guard bytes on both sides of the second target
    add_step(3'd5, op_wr, 13'h07df, 8'ha5, 8'h00);
    add_step(3'd5, op_wr, 13'h07f4, 8'h5a, 8'h00);
    add_step(3'd5, op_dma, 13'h07e0, 8'h01, 8'h00);
    add_step(3'd5, op_wait, 13'h0000, 8'h00, 8'h00);
    for (i = 0; i < 20; i++) begin
      add_step(3'd5, op_rd, 13'h07e0 + 13'(i), 8'h00, exp_byte(dma_src + 24'(i)));
    end
    add_step(3'd5, op_rd, 13'h07df, 8'h00, 8'ha5);
    add_step(3'd5, op_rd, 13'h07f4, 8'h00, 8'h5a);
  endtask

  initial begin
    int i;
    checks      = 0;
    errors      = 0;
    mark_checks = 0;
    mark_errors = 0;
    timed_out   = 1'b0;
    reset       = 1'b1;
    DI          = 8'h00;
    ADDR        = '0;
    CS          = 1'b0;
    nWR         = 1'b1;
    bus_slow    = 1'b0;
    build_table();
    repeat (16) @(posedge CLK);
    reset <= 1'b0;
    @(negedge CLK);
    compare({7'b0, cx4_active}, 8'h00, "cx4_active after reset");
    compare({7'b0, BUS_RRQ}, 8'h00, "BUS_RRQ after reset");
    for (i = 0; i < steps.size() && !timed_out; i++) begin
      run_step(steps[i]);
      if (i == steps.size() - 1 || steps[i+1].test != steps[i].test) begin
        $display("test %0d (%s): %0d checks, %0d errors", steps[i].test,
                 test_name(steps[i].test), checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
      end
    end
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
logic/cx4_pkg.sv
logic/cx4_host_port.sv
logic/cx4_mmio_regs.sv
logic/cx4_dma_engine.sv
logic/cx4_datram.sv
logic/cx4_top.sv
dv/cx4_bus_model.sv
dv/tb_cx4.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_cx4 -f tb.f \
  && ./obj_dir/Vtb_cx4 | tee /dev/stderr | grep -qx "Result: PASSED" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
